// ==== pkt_resize_pkg.sv ====
// Shared types and constants for the packet resizer.
// Every resizer module refers to these by pkt_resize_pkg:: scoped names.

`default_nettype none

package pkt_resize_pkg;

  ////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////

  // One input or output sample
  typedef logic [31:0] sample_t;

  // Stream ID for source and destination alike
  typedef logic [15:0] sid_t;

  // Packet length in words
  typedef logic [15:0] pkt_len_t;

  // Header sequence number that wraps at 4096
  typedef logic [11:0] seqnum_t;

  // Settings bus
  typedef logic [7:0]  set_addr_t;
  typedef logic [31:0] set_data_t;

  // Packet boundary FSM
  typedef enum logic [0:0] {
    FIRST,  // next accepted word opens a packet
    BODY    // packet in progress
  } resize_state_t;

  ////////////////////////////////////////
  // Register map and reset values
  ////////////////////////////////////////

  localparam set_addr_t SR_NEXT_DST = 8'd128;
  localparam set_addr_t SR_PKT_SIZE = 8'd129;

  localparam pkt_len_t PKT_SIZE_RESET = 16'd32;
  localparam sid_t     NEXT_DST_RESET = 16'd0;

endpackage

`default_nettype wire

// ==== pkt_resize_regs.sv ====
// Settings-bus decoder for the resizer user registers.
// Holds the packet size and the next destination ID.

`timescale 1ns/1ps
`default_nettype none

module pkt_resize_regs (
  input  wire                        i_ce_clk,
  input  wire                        i_rst_n,
  input  wire                        i_set_stb,
  input  pkt_resize_pkg::set_addr_t  i_set_addr,
  input  pkt_resize_pkg::set_data_t  i_set_data,
  output pkt_resize_pkg::pkt_len_t   o_pkt_size,
  output pkt_resize_pkg::sid_t       o_next_dst
);

  pkt_resize_pkg::pkt_len_t pkt_size_q;
  pkt_resize_pkg::sid_t     next_dst_q;
  pkt_resize_pkg::pkt_len_t size_wr;

  // Zero size is stored as a one-word packet
  always_comb begin
    size_wr = i_set_data[15:0];
    if (size_wr == '0) begin
      size_wr = 16'd1;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (!i_rst_n) begin
      pkt_size_q <= pkt_resize_pkg::PKT_SIZE_RESET;
      next_dst_q <= pkt_resize_pkg::NEXT_DST_RESET;
    end else if (i_set_stb) begin
      case (i_set_addr)
        pkt_resize_pkg::SR_PKT_SIZE: pkt_size_q <= size_wr;
        pkt_resize_pkg::SR_NEXT_DST: next_dst_q <= i_set_data[15:0];
        // Other addresses belong to someone else
        default: ;
      endcase
    end
  end

  assign o_pkt_size = pkt_size_q;
  assign o_next_dst = next_dst_q;

endmodule

`default_nettype wire

// ==== pkt_resize_count.sv ====
// Word counter within the current output packet.
// Flags the word that closes the packet so the header logic can mark it last.

`timescale 1ns/1ps
`default_nettype none

module pkt_resize_count (
  input  wire                       i_ce_clk,
  input  wire                       i_rst_n,
  input  wire                       i_take,
  input  pkt_resize_pkg::pkt_len_t  i_pkt_size,
  output logic                      o_at_last
);

  pkt_resize_pkg::pkt_len_t cnt_q;
  pkt_resize_pkg::pkt_len_t last_idx;

  // Size is never below one, so this cannot underflow
  assign last_idx  = i_pkt_size - 16'd1;
  assign o_at_last = (cnt_q == last_idx);

  always_ff @(posedge i_ce_clk) begin
    if (!i_rst_n) begin
      cnt_q <= '0;
    end else if (i_take) begin
      if (o_at_last) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== pkt_resize_fsm.sv ====
// Packet boundary control: latches size, source and destination at each
// packet start and steps the sequence number after each packet's last word.

`timescale 1ns/1ps
`default_nettype none

module pkt_resize_fsm (
  input  wire                       i_ce_clk,
  input  wire                       i_rst_n,
  input  wire                       i_take,
  input  wire                       i_at_last,
  input  wire                       i_clear_seqnum,
  input  pkt_resize_pkg::sid_t      i_src,
  input  pkt_resize_pkg::pkt_len_t  i_pkt_size,
  input  pkt_resize_pkg::sid_t      i_next_dst,
  output pkt_resize_pkg::pkt_len_t  o_cur_size,
  output pkt_resize_pkg::sid_t      o_cur_src,
  output pkt_resize_pkg::sid_t      o_cur_dst,
  output pkt_resize_pkg::seqnum_t   o_seqnum,
  output logic                      o_start
);

  pkt_resize_pkg::resize_state_t state_q;
  pkt_resize_pkg::pkt_len_t      size_q;
  pkt_resize_pkg::sid_t          src_q;
  pkt_resize_pkg::sid_t          dst_q;
  pkt_resize_pkg::seqnum_t       seq_q;
  logic                          clr_pend_q;
  logic                          clr_now;

  assign o_start = (state_q == pkt_resize_pkg::FIRST);
  assign clr_now = clr_pend_q | i_clear_seqnum;

  // First word sees the live size and the cleared seqnum
  assign o_cur_size = o_start ? i_pkt_size : size_q;
  assign o_seqnum   = (o_start && clr_now) ? '0 : seq_q;
  assign o_cur_src  = src_q;
  assign o_cur_dst  = dst_q;

  ////////////////////////////////////////
  // State and sequence number
  ////////////////////////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (!i_rst_n) begin
      state_q    <= pkt_resize_pkg::FIRST;
      seq_q      <= '0;
      clr_pend_q <= 1'b0;
    end else begin
      // Clear waits for the next packet start
      if (i_take && o_start) begin
        clr_pend_q <= 1'b0;
      end else if (i_clear_seqnum) begin
        clr_pend_q <= 1'b1;
      end
      if (i_take) begin
        if (i_at_last) begin
          state_q <= pkt_resize_pkg::FIRST;
          seq_q   <= o_seqnum + 12'd1;
        end else begin
          state_q <= pkt_resize_pkg::BODY;
          seq_q   <= o_seqnum;
        end
      end
    end
  end

  // Per-packet fields, held for the body words
  always_ff @(posedge i_ce_clk) begin
    if (i_take && o_start) begin
      size_q <= i_pkt_size;
      src_q  <= i_src;
      dst_q  <= i_next_dst;
    end
  end

endmodule

`default_nettype wire

// ==== pkt_resize_out.sv ====
// One-entry output register for the resized stream.
// Loads data, last and the sideband header on every accepted word.

`timescale 1ns/1ps
`default_nettype none

module pkt_resize_out (
  input  wire                       i_ce_clk,
  input  wire                       i_rst_n,
  // Upstream samples
  input  pkt_resize_pkg::sample_t   i_tdata,
  input  wire                       i_tvalid,
  output logic                      o_tready,
  // Header sources
  input  wire                       i_at_last,
  input  wire                       i_start,
  input  pkt_resize_pkg::sid_t      i_src,
  input  pkt_resize_pkg::sid_t      i_cur_src,
  input  pkt_resize_pkg::sid_t      i_cur_dst,
  input  pkt_resize_pkg::sid_t      i_next_dst,
  input  pkt_resize_pkg::seqnum_t   i_seqnum,
  output logic                      o_take,
  // Downstream packets
  output pkt_resize_pkg::sample_t   o_tdata,
  output logic                      o_tlast,
  output pkt_resize_pkg::seqnum_t   o_tuser_seqnum,
  output pkt_resize_pkg::sid_t      o_tuser_src,
  output pkt_resize_pkg::sid_t      o_tuser_dst,
  output logic                      o_tvalid,
  input  wire                       i_tready
);

  logic                    valid_q;
  pkt_resize_pkg::sample_t data_q;
  logic                    last_q;
  pkt_resize_pkg::seqnum_t seq_q;
  pkt_resize_pkg::sid_t    src_q;
  pkt_resize_pkg::sid_t    dst_q;

  // Room when empty or when the sink drains this cycle
  assign o_tready = !valid_q || i_tready;
  assign o_take   = i_tvalid && o_tready;

  always_ff @(posedge i_ce_clk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (o_take) begin
      valid_q <= 1'b1;
    end else if (i_tready) begin
      valid_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Payload and header
  ////////////////////////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (o_take) begin
      data_q <= i_tdata;
      last_q <= i_at_last;
      seq_q  <= i_seqnum;
      // FSM latches arrive one edge late for the opening word
      src_q  <= i_start ? i_src : i_cur_src;
      dst_q  <= i_start ? i_next_dst : i_cur_dst;
    end
  end

  assign o_tvalid       = valid_q;
  assign o_tdata        = data_q;
  assign o_tlast        = last_q;
  assign o_tuser_seqnum = seq_q;
  assign o_tuser_src    = src_q;
  assign o_tuser_dst    = dst_q;

endmodule

`default_nettype wire

// ==== pkt_resize_top.sv ====
// Packet resizer user logic: regroups a sample stream into packets of
// programmable length with a sequence, source and destination header.

`timescale 1ns/1ps
`default_nettype none

module pkt_resize_top (
  input  wire                       i_ce_clk,
  input  wire                       i_rst_n,
  // Settings bus
  input  wire                       i_set_stb,
  input  pkt_resize_pkg::set_addr_t i_set_addr,
  input  pkt_resize_pkg::set_data_t i_set_data,
  // Input stream without a last flag
  input  pkt_resize_pkg::sample_t   i_tdata,
  input  pkt_resize_pkg::sid_t      i_tuser,
  input  wire                       i_tvalid,
  output logic                      o_tready,
  // Output stream
  output pkt_resize_pkg::sample_t   o_tdata,
  output logic                      o_tlast,
  output pkt_resize_pkg::seqnum_t   o_tuser_seqnum,
  output pkt_resize_pkg::sid_t      o_tuser_src,
  output pkt_resize_pkg::sid_t      o_tuser_dst,
  output logic                      o_tvalid,
  input  wire                       i_tready,
  input  wire                       i_clear_seqnum
);

  pkt_resize_pkg::pkt_len_t pkt_size;
  pkt_resize_pkg::sid_t     next_dst;
  pkt_resize_pkg::pkt_len_t cur_size;
  pkt_resize_pkg::sid_t     cur_src;
  pkt_resize_pkg::sid_t     cur_dst;
  pkt_resize_pkg::seqnum_t  seqnum;
  logic                     start;
  logic                     take;
  logic                     at_last;

  ////////////////////////////////////////
  // User registers
  ////////////////////////////////////////

  pkt_resize_regs regs0 (
    .i_ce_clk   (i_ce_clk),
    .i_rst_n    (i_rst_n),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .o_pkt_size (pkt_size),
    .o_next_dst (next_dst)
  );

  ////////////////////////////////////////
  // Packet control
  ////////////////////////////////////////

  pkt_resize_fsm fsm0 (
    .i_ce_clk       (i_ce_clk),
    .i_rst_n        (i_rst_n),
    .i_take         (take),
    .i_at_last      (at_last),
    .i_clear_seqnum (i_clear_seqnum),
    .i_src          (i_tuser),
    .i_pkt_size     (pkt_size),
    .i_next_dst     (next_dst),
    .o_cur_size     (cur_size),
    .o_cur_src      (cur_src),
    .o_cur_dst      (cur_dst),
    .o_seqnum       (seqnum),
    .o_start        (start)
  );

  pkt_resize_count count0 (
    .i_ce_clk   (i_ce_clk),
    .i_rst_n    (i_rst_n),
    .i_take     (take),
    .i_pkt_size (cur_size),
    .o_at_last  (at_last)
  );

  ////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////

  pkt_resize_out out0 (
    .i_ce_clk       (i_ce_clk),
    .i_rst_n        (i_rst_n),
    .i_tdata        (i_tdata),
    .i_tvalid       (i_tvalid),
    .o_tready       (o_tready),
    .i_at_last      (at_last),
    .i_start        (start),
    .i_src          (i_tuser),
    .i_cur_src      (cur_src),
    .i_cur_dst      (cur_dst),
    .i_next_dst     (next_dst),
    .i_seqnum       (seqnum),
    .o_take         (take),
    .o_tdata        (o_tdata),
    .o_tlast        (o_tlast),
    .o_tuser_seqnum (o_tuser_seqnum),
    .o_tuser_src    (o_tuser_src),
    .o_tuser_dst    (o_tuser_dst),
    .o_tvalid       (o_tvalid),
    .i_tready       (i_tready)
  );

endmodule

`default_nettype wire

// ==== tb_pkt_resize.sv ====
// Self-checking testbench for the packet resizer top level.
// Streams LFSR samples through size, destination and clear changes and checks every output word.

`timescale 1ns/1ps
`default_nettype none

module tb_pkt_resize;

  localparam int N_RESET  = 96;
  localparam int N_RESIZE = 60;
  localparam int N_CLEAR  = 50;
  localparam int N_SINGLE = 4200;
  localparam int N_RANDOM = 400;
  localparam int TOTAL_WORDS = N_RESET + N_RESIZE + N_CLEAR + N_SINGLE + N_RANDOM;
  localparam int TIMEOUT_CYC = TOTAL_WORDS * 8 + 2000;

  logic clk;
  logic rst_n;
  logic set_stb;
  logic clear_seqnum;
  logic in_tvalid;
  logic in_tready;
  logic out_tlast;
  logic out_tvalid;
  logic out_tready;
  logic bp_on;
  pkt_resize_pkg::set_addr_t set_addr;
  pkt_resize_pkg::set_data_t set_data;
  pkt_resize_pkg::sample_t   in_tdata;
  pkt_resize_pkg::sample_t   out_tdata;
  pkt_resize_pkg::sid_t      in_tuser;
  pkt_resize_pkg::sid_t      out_src;
  pkt_resize_pkg::sid_t      out_dst;
  pkt_resize_pkg::seqnum_t   out_seqnum;

  // Reference model state, updated once per clock at the falling edge
  pkt_resize_pkg::pkt_len_t reg_size = pkt_resize_pkg::PKT_SIZE_RESET;
  pkt_resize_pkg::sid_t     reg_dst  = pkt_resize_pkg::NEXT_DST_RESET;
  pkt_resize_pkg::pkt_len_t pkt_size = '0;
  pkt_resize_pkg::sid_t     pkt_dst  = '0;
  pkt_resize_pkg::sid_t     pkt_src  = '0;
  pkt_resize_pkg::pkt_len_t widx     = '0;
  int unsigned pkt_cnt  = 0;
  logic        clr_pend = 1'b0;
  logic        will_take = 1'b0;
  logic        held = 1'b0;
  logic [31:0] lfsr = 32'h49c3_93c8;
  int          errors = 0;
  int          words_in = 0;
  int          words_out = 0;

  pkt_resize_pkg::sample_t exp_data[$];
  pkt_resize_pkg::sid_t    exp_src[$];
  logic [28:0]             exp_hdr[$];

  // Output fields seen while the sink stalls
  pkt_resize_pkg::sample_t saved_data;
  logic                    saved_last;
  pkt_resize_pkg::seqnum_t saved_seq;
  pkt_resize_pkg::sid_t    saved_src;
  pkt_resize_pkg::sid_t    saved_dst;

  pkt_resize_top dut0 (
    .i_ce_clk       (clk),
    .i_rst_n        (rst_n),
    .i_set_stb      (set_stb),
    .i_set_addr     (set_addr),
    .i_set_data     (set_data),
    .i_tdata        (in_tdata),
    .i_tuser        (in_tuser),
    .i_tvalid       (in_tvalid),
    .o_tready       (in_tready),
    .o_tdata        (out_tdata),
    .o_tlast        (out_tlast),
    .o_tuser_seqnum (out_seqnum),
    .o_tuser_src    (out_src),
    .o_tuser_dst    (out_dst),
    .o_tvalid       (out_tvalid),
    .i_tready       (out_tready),
    .i_clear_seqnum (clear_seqnum)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // Expected {last, seqnum, dst} for word idx of a packet
  function automatic logic [28:0] expect_hdr(input pkt_resize_pkg::pkt_len_t idx,
                                             input pkt_resize_pkg::pkt_len_t size,
                                             input pkt_resize_pkg::sid_t dst,
                                             input int unsigned cnt);
    logic last;
    last = (idx + 16'd1 == size);
    return {last, cnt[11:0], dst};
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic write_reg(input pkt_resize_pkg::set_addr_t addr,
                           input pkt_resize_pkg::set_data_t data);
    @(posedge clk);
    set_stb  <= 1'b1;
    set_addr <= addr;
    set_data <= data;
    @(posedge clk);
    set_stb  <= 1'b0;
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    clear_seqnum <= 1'b1;
    @(posedge clk);
    clear_seqnum <= 1'b0;
  endtask

  // Presents n words, holding each until the DUT takes it
  task automatic send_words(input int n, input logic gaps);
    int          queued;
    int          done_n;
    logic [31:0] r;
    queued = 0;
    done_n = 0;
    while (done_n < n) begin
      @(posedge clk);
      if (will_take) done_n++;
      if (!in_tvalid || will_take) begin
        r = gaps ? take_bits(2) : 32'd1;
        if (queued < n && r[1:0] != 2'b00) begin
          in_tvalid <= 1'b1;
          in_tdata  <= take_bits(32);
          r = take_bits(16);
          in_tuser  <= r[15:0];
          queued++;
        end else begin
          in_tvalid <= 1'b0;
        end
      end
    end
  endtask

  // Sink ready is random only while back-pressure is on
  initial begin : sink_proc
    logic [31:0] r;
    out_tready <= 1'b1;
    forever begin
      @(posedge clk);
      r = bp_on ? take_bits(1) : 32'd1;
      out_tready <= r[0];
    end
  end

  ////////////////////////////////////////
  // Model and compare at the falling edge
  ////////////////////////////////////////

  always @(negedge clk) begin : compare_proc
    logic [28:0] hdr;
    will_take = rst_n && in_tvalid && in_tready;
    if (rst_n) begin
      // Room upstream when the output is empty or draining
      check("tready", 32'(in_tready), 32'(!out_tvalid || out_tready));
      if (held) begin
        check("tvalid held", 32'(out_tvalid), 32'd1);
        check("held tdata", out_tdata, saved_data);
        check("held tlast", 32'(out_tlast), 32'(saved_last));
        check("held tuser_seqnum", 32'(out_seqnum), 32'(saved_seq));
        check("held tuser_src", 32'(out_src), 32'(saved_src));
        check("held tuser_dst", 32'(out_dst), 32'(saved_dst));
      end
      if (out_tvalid && out_tready) begin
        if (exp_data.size() == 0) begin
          $display("Output word at %0t ns with no input word outstanding", $time);
          errors++;
        end else begin
          hdr = exp_hdr.pop_front();
          check("tdata", out_tdata, exp_data.pop_front());
          check("tuser_src", 32'(out_src), 32'(exp_src.pop_front()));
          check("tlast", 32'(out_tlast), 32'(hdr[28]));
          check("tuser_seqnum", 32'(out_seqnum), 32'(hdr[27:16]));
          check("tuser_dst", 32'(out_dst), 32'(hdr[15:0]));
        end
        words_out++;
      end
      held       = out_tvalid && !out_tready;
      saved_data = out_tdata;
      saved_last = out_tlast;
      saved_seq  = out_seqnum;
      saved_src  = out_src;
      saved_dst  = out_dst;
      // Input side uses the registers as they stand before this edge
      if (clear_seqnum) clr_pend = 1'b1;
      if (will_take) begin
        if (widx == 16'd0) begin
          if (clr_pend) pkt_cnt = 0;
          clr_pend = 1'b0;
          pkt_size = reg_size;
          pkt_dst  = reg_dst;
          pkt_src  = in_tuser;
        end
        hdr = expect_hdr(widx, pkt_size, pkt_dst, pkt_cnt);
        exp_data.push_back(in_tdata);
        exp_src.push_back(pkt_src);
        exp_hdr.push_back(hdr);
        words_in++;
        if (hdr[28]) begin
          widx = '0;
          pkt_cnt++;
        end else begin
          widx = widx + 16'd1;
        end
      end
      if (set_stb && set_addr == pkt_resize_pkg::SR_PKT_SIZE) begin
        reg_size = (set_data[15:0] == 16'd0) ? 16'd1 : set_data[15:0];
      end
      if (set_stb && set_addr == pkt_resize_pkg::SR_NEXT_DST) reg_dst = set_data[15:0];
    end
  end

  initial begin : watchdog_proc
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("Timeout after %0d cycles, the stream stopped moving", TIMEOUT_CYC);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main_proc
    rst_n        <= 1'b0;
    set_stb      <= 1'b0;
    set_addr     <= '0;
    set_data     <= '0;
    clear_seqnum <= 1'b0;
    in_tvalid    <= 1'b0;
    in_tdata     <= '0;
    in_tuser     <= '0;
    bp_on        <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    send_words(N_RESET, 1'b0);
    // Size and destination change while a packet is open
    fork
      send_words(N_RESIZE, 1'b0);
      begin
        repeat (10) @(posedge clk);
        write_reg(pkt_resize_pkg::SR_PKT_SIZE, 32'd12);
        repeat (5) @(posedge clk);
        write_reg(pkt_resize_pkg::SR_NEXT_DST, 32'h0000_0abc);
      end
    join
    fork
      send_words(N_CLEAR, 1'b1);
      begin
        repeat (7) @(posedge clk);
        pulse_clear();
      end
    join
    // Single-word packets that wrap the sequence number
    write_reg(pkt_resize_pkg::SR_PKT_SIZE, 32'd0);
    fork
      send_words(N_SINGLE, 1'b0);
      begin
        repeat (100) @(posedge clk);
        write_reg(pkt_resize_pkg::SR_NEXT_DST, 32'h1234_5a5a);
      end
    join
    write_reg(pkt_resize_pkg::SR_PKT_SIZE, 32'd7);
    bp_on <= 1'b1;
    send_words(N_RANDOM, 1'b1);
    bp_on <= 1'b0;
    while (exp_data.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    check("words out vs in", 32'(words_out), 32'(words_in));
    $display("Words checked %0d, errors %0d", words_out, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
pkt_resize_pkg.sv
pkt_resize_regs.sv
pkt_resize_count.sv
pkt_resize_fsm.sv
pkt_resize_out.sv
pkt_resize_top.sv
tb_pkt_resize.sv

// ==== Makefile ====
# Verilator simulation of the packet resizer testbench

VERILATOR ?= verilator
TOP       ?= tb_pkt_resize
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
